/* dv/tb_peri_subsystem.sv */
/*
 * Table-driven testbench for the peripheral bus subsystem.
 * Each row is a bus write, bus read, input pulse train or pin check.
 */
`timescale 1ns/1ps

module tb_peri_subsystem import peri_pkg::*;;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_PULSE, OP_PINS, OP_INPUT, OP_HOLD} op_e;

    // For OP_PULSE wdata is the pin and exp the pulse count
    // For OP_HOLD wdata is the input byte driven while the read is held
    typedef struct packed {
        op_e       op;
        addr_t     addr;
        data_t     wdata;
        data_t     exp;
        bus_size_e size;
    } row_t;

    localparam addr_t GPIO_OUT_ADDR = 11'h040;
    localparam addr_t GPIO_IN_ADDR  = 11'h044;

    logic      clk;
    logic      rst_n;
    byte_t     ui_in;
    addr_t     addr;
    data_t     data_in;
    bus_size_e data_write_n;
    bus_size_e data_read_n;
    logic      data_read_complete;
    data_t     data_out;
    logic      data_ready;
    byte_t     uo_out;

    row_t   rows [$];
    integer seed;
    int     errors;
    int     checks;
    int     cycle_count;
    int     cycle_limit;

    peri_subsystem #(
        .NUM_SLOTS            (4)
    ) DUT (
        .i_clk                (clk),
        .i_rst_n              (rst_n),
        .i_ui_in              (ui_in),
        .i_addr               (addr),
        .i_data_in            (data_in),
        .i_data_write_n       (data_write_n),
        .i_data_read_n        (data_read_n),
        .i_data_read_complete (data_read_complete),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .o_uo_out             (uo_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_data(input data_t got, input data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_pins(input byte_t got, input byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s are 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_ready(input logic got, input string what);
        checks++;
        if (got !== 1'b1) begin
            errors++;
            $display("Fail at %0t ns: %s, o_data_ready is %b", $time, what, got);
        end
    endtask

    function automatic addr_t sel_addr(input int pin);
        return addr_t'(11'h060 + pin * 4);
    endfunction

    function automatic addr_t slot_addr(input int slot, input int ofs);
        return addr_t'(11'h400 + slot * 16 + ofs);
    endfunction

    function automatic void add_row(input op_e op, input addr_t a, input data_t wdata,
                                    input data_t exp, input bus_size_e size = BUS_WORD);
        row_t r;
        r.op    = op;
        r.addr  = a;
        r.wdata = wdata;
        r.exp   = exp;
        r.size  = size;
        rows.push_back(r);
    endfunction

    // Write ack must be visible in the same cycle as the request
    task automatic write_reg(input addr_t a, input data_t wdata, input bus_size_e size);
        @(negedge clk);
        addr         = a;
        data_in      = wdata;
        data_write_n = size;
        #1;
        check_ready(data_ready, "no acknowledge during write");
        @(negedge clk);
        data_write_n = BUS_NONE;
    endtask

    task automatic read_reg(input addr_t a, input data_t exp, input int delay,
                            input logic drive_in, input byte_t new_in);
        data_t first;
        @(negedge clk);
        addr        = a;
        data_read_n = BUS_WORD;
        @(negedge clk);
        while (!data_ready) begin
            @(negedge clk);
        end
        first = data_out;
        check_data(first, exp, "read data");
        // Complete is held back, data must not move meanwhile
        for (int d = 0; d < delay; d++) begin
            if (drive_in) begin
                ui_in = new_in;
            end
            @(negedge clk);
            check_data(data_out, first, "held read data");
        end
        data_read_complete = 1'b1;
        @(negedge clk);
        data_read_complete = 1'b0;
        data_read_n        = BUS_NONE;
    endtask

    // Each pulse is 3 cycles high then 3 cycles low
    task automatic pulse_pin(input int pin, input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            ui_in[pin] = 1'b1;
            repeat (3) @(negedge clk);
            ui_in[pin] = 1'b0;
            repeat (2) @(negedge clk);
        end
    endtask

    function automatic void build_table();
        add_row(OP_READ, GPIO_OUT_ADDR, 32'h0, 32'h0);
        for (int k = 0; k < NUM_PINS; k++) begin
            add_row(OP_READ, sel_addr(k), 32'h0, 32'h1);
        end
        for (int s = 0; s < 4; s++) begin
            for (int r = 0; r < 3; r++) begin
                add_row(OP_READ, slot_addr(s, r), 32'h0, 32'h0);
            end
        end
        add_row(OP_PINS, '0, 32'h0, 32'h00);
        // GPIO output, input register and pins with every select at GPIO
        add_row(OP_WRITE, GPIO_OUT_ADDR, 32'h0000_12A5, 32'h0, BUS_WORD);
        add_row(OP_READ, GPIO_OUT_ADDR, 32'h0, 32'hA5);
        add_row(OP_PINS, '0, 32'h0, 32'hA5);
        add_row(OP_INPUT, '0, 32'h3C, 32'h0);
        add_row(OP_READ, GPIO_IN_ADDR, 32'h0, 32'h3C);
        add_row(OP_READ, 11'h048, 32'h0, 32'h0);
        add_row(OP_INPUT, '0, 32'h00, 32'h0);
        // Pin 3 follows slot 2, then pin 0 asks for slot 4 which is not fitted
        add_row(OP_WRITE, slot_addr(2, 0), 32'hFF, 32'h0, BUS_BYTE);
        add_row(OP_READ, slot_addr(2, 0), 32'h0, 32'hFF);
        add_row(OP_WRITE, sel_addr(3), 32'd18, 32'h0, BUS_BYTE);
        add_row(OP_PINS, '0, 32'h0, 32'hAD);
        add_row(OP_WRITE, slot_addr(2, 0), 32'hF7, 32'h0, BUS_BYTE);
        add_row(OP_PINS, '0, 32'h0, 32'hA5);
        add_row(OP_WRITE, sel_addr(0), 32'd20, 32'h0, BUS_HALF);
        add_row(OP_READ, sel_addr(0), 32'h0, 32'd20);
        add_row(OP_PINS, '0, 32'h0, 32'hA4);
        add_row(OP_WRITE, sel_addr(0), 32'h1, 32'h0, BUS_WORD);
        add_row(OP_WRITE, sel_addr(3), 32'h1, 32'h0, BUS_WORD);
        add_row(OP_WRITE, GPIO_OUT_ADDR, 32'h0000_BE3C, 32'h0, BUS_HALF);
        add_row(OP_READ, GPIO_OUT_ADDR, 32'h0, 32'h3C);
        add_row(OP_PINS, '0, 32'h0, 32'h3C);
        // Slot 0 counts pin 2, slot 1 counts pin 5
        add_row(OP_WRITE, slot_addr(0, 2), 32'h2, 32'h0, BUS_BYTE);
        add_row(OP_WRITE, slot_addr(1, 2), 32'h5, 32'h0, BUS_WORD);
        add_row(OP_READ, slot_addr(0, 2), 32'h0, 32'h2);
        add_row(OP_PULSE, '0, 32'd2, 32'd5);
        add_row(OP_READ, slot_addr(0, 1), 32'h0, 32'd5);
        add_row(OP_READ, slot_addr(1, 1), 32'h0, 32'd0);
        add_row(OP_READ, slot_addr(3, 1), 32'h0, 32'd0);
        add_row(OP_WRITE, slot_addr(0, 1), 32'h77, 32'h0, BUS_BYTE);
        add_row(OP_READ, slot_addr(0, 1), 32'h0, 32'd0);
        add_row(OP_PULSE, '0, 32'd5, 32'd3);
        add_row(OP_READ, slot_addr(1, 1), 32'h0, 32'd3);
        add_row(OP_READ, slot_addr(0, 1), 32'h0, 32'd0);
        // Held read while pin 6 rises, then unmapped addresses
        add_row(OP_HOLD, GPIO_IN_ADDR, 32'h40, 32'h00);
        add_row(OP_READ, GPIO_IN_ADDR, 32'h0, 32'h40);
        // A write to slot 5 must not land in slot 1, the same index modulo 4
        add_row(OP_WRITE, 11'h450, 32'hFF, 32'h0, BUS_WORD);
        add_row(OP_READ, 11'h450, 32'h0, 32'h0);
        add_row(OP_READ, slot_addr(1, 0), 32'h0, 32'h0);
        add_row(OP_READ, 11'h7F0, 32'h0, 32'h0);
        add_row(OP_READ, 11'h000, 32'h0, 32'h0);
        add_row(OP_PINS, '0, 32'h0, 32'h3C);
    endfunction

    task automatic run_row(input int idx, input row_t r);
        int errors_before;
        int delay;
        errors_before = errors;
        case (r.op)
            OP_WRITE: write_reg(r.addr, r.wdata, r.size);
            OP_READ: begin
                delay = $random(seed) & 3;
                read_reg(r.addr, r.exp, delay, 1'b0, 8'h00);
            end
            OP_HOLD:  read_reg(r.addr, r.exp, 3, 1'b1, r.wdata[7:0]);
            OP_PULSE: pulse_pin(int'(r.wdata[2:0]), int'(r.exp));
            OP_PINS: begin
                @(negedge clk);
                check_pins(uo_out, r.exp[7:0], "output pins");
            end
            OP_INPUT: begin
                @(negedge clk);
                ui_in = r.wdata[7:0];
            end
            default: begin
                errors++;
                $display("Row %0d holds an unknown operation", idx);
            end
        endcase
        $display("row %0d %s addr 0x%03h: %s", idx, r.op.name(), r.addr,
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        cycle_count = 0;
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timed out, the run did not finish within %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed               = 32'h7b85;
        errors             = 0;
        checks             = 0;
        cycle_limit        = 0;
        rst_n              = 1'b0;
        ui_in              = 8'h00;
        addr               = '0;
        data_in            = '0;
        data_write_n       = BUS_NONE;
        data_read_n        = BUS_NONE;
        data_read_complete = 1'b0;
        build_table();
        cycle_limit = rows.size() * 40 + 8;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        foreach (rows[i]) begin
            run_row(i, rows[i]);
        end
        $display("Rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* hw/peri_addr_decode.sv */
/*
 * Address decoder: picks GPIO, a byte slot or nothing from the bus address.
 * Also produces the write strobes for the selected block.
 */
`timescale 1ns/1ps

module peri_addr_decode import peri_pkg::*; #(
    parameter int NUM_SLOTS = 4
) (
    input  addr_t                i_addr,
    input  bus_size_e            i_data_write_n,
    output peri_target_e         o_target,
    output logic [3:0]           o_slot_idx,
    output logic                 o_gpio_wr,
    output logic [NUM_SLOTS-1:0] o_slot_wr
);

    localparam int SLOT_IDX_LSB = $clog2(SLOT_WINDOW);
    // The slot region holds at most 16 windows
    localparam int SLOT_REGION  = 16 * SLOT_WINDOW;

    addr_t slot_rel;
    logic  in_gpio;
    logic  in_slot_region;
    logic  wr_req;

    assign slot_rel       = i_addr - SLOT_BASE;
    assign o_slot_idx     = slot_rel[SLOT_IDX_LSB +: 4];

    assign in_gpio        = (i_addr >= GPIO_BASE) && (i_addr < GPIO_BASE + GPIO_WINDOW);
    assign in_slot_region = (i_addr >= SLOT_BASE) && (i_addr < SLOT_BASE + SLOT_REGION);

    assign wr_req         = (i_data_write_n != BUS_NONE);

    always_comb begin
        o_target = TGT_NONE;
        if (in_gpio) begin
            o_target = TGT_GPIO;
        end else if (in_slot_region && (int'(o_slot_idx) < NUM_SLOTS)) begin
            // Slots beyond the fitted count stay unmapped
            o_target = TGT_SLOT;
        end
    end

    assign o_gpio_wr = wr_req && (o_target == TGT_GPIO);

    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            o_slot_wr[s] = wr_req && (o_target == TGT_SLOT) && (int'(o_slot_idx) == s);
        end
    end

endmodule

/* hw/peri_byte_slot.sv */
/*
 * Byte peripheral slot: output byte, input pin select and a rising-edge
 * counter on the selected input. One copy per slot at the top level.
 */
`timescale 1ns/1ps

module peri_byte_slot import peri_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  byte_t      i_ui_in,
    input  logic       i_wr,
    input  logic [3:0] i_ofs,
    input  byte_t      i_wdata,
    output byte_t      o_out,
    output byte_t      o_rdata
);

    byte_t      out_q;
    logic [2:0] pin_sel_q;
    byte_t      count_q;
    logic       pin_q;
    logic       pin_prev_q;
    logic       rise;

    // Two sample stages, so a rise counts on the second edge after it
    assign rise = pin_q && !pin_prev_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            out_q      <= '0;
            pin_sel_q  <= '0;
            pin_q      <= 1'b0;
            pin_prev_q <= 1'b0;
        end else begin
            pin_q      <= i_ui_in[pin_sel_q];
            pin_prev_q <= pin_q;
            if (i_wr && (i_ofs == SLOT_OUT_OFS)) begin
                out_q <= i_wdata;
            end
            if (i_wr && (i_ofs == SLOT_PIN_OFS)) begin
                pin_sel_q <= i_wdata[2:0];
            end
        end
    end

    // Counter wraps at 256
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            count_q <= '0;
        end else if (i_wr && (i_ofs == SLOT_COUNT_OFS)) begin
            // Any write value clears the count
            count_q <= '0;
        end else if (rise) begin
            count_q <= count_q + 8'd1;
        end
    end

    assign o_out = out_q;

    always_comb begin
        case (i_ofs)
            SLOT_OUT_OFS:   o_rdata = out_q;
            SLOT_COUNT_OFS: o_rdata = count_q;
            SLOT_PIN_OFS:   o_rdata = {5'h0, pin_sel_q};
            default:        o_rdata = '0;
        endcase
    end

endmodule

/* hw/peri_gpio.sv */
/*
 * GPIO block: output byte, live input byte and per-pin function selects.
 * Writes take the low data byte; reads return the register zero-extended.
 */
`timescale 1ns/1ps

module peri_gpio import peri_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  byte_t     i_ui_in,
    input  logic      i_wr,
    input  logic [5:0] i_ofs,
    input  byte_t     i_wdata,
    output byte_t     o_gpio_out,
    output func_sel_t o_func_sel [NUM_PINS],
    output data_t     o_rdata
);

    localparam int SEL_SHIFT = $clog2(GPIO_SEL_STRIDE);
    localparam int PIN_W     = $clog2(NUM_PINS);

    byte_t              gpio_out_q;
    func_sel_t          func_sel_q [NUM_PINS];
    logic [5:0]         sel_rel;
    logic               sel_hit;
    logic [PIN_W-1:0]   sel_pin;

    // Function selects sit on a word stride above GPIO_SEL_OFS
    assign sel_rel = i_ofs - GPIO_SEL_OFS;
    assign sel_hit = (i_ofs >= GPIO_SEL_OFS)
                  && (sel_rel[SEL_SHIFT-1:0] == '0)
                  && (sel_rel < NUM_PINS * GPIO_SEL_STRIDE);
    assign sel_pin = sel_rel[SEL_SHIFT +: PIN_W];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            gpio_out_q <= '0;
            for (int p = 0; p < NUM_PINS; p++) begin
                func_sel_q[p] <= FUNC_GPIO;
            end
        end else if (i_wr) begin
            if (i_ofs == GPIO_OUT_OFS) begin
                gpio_out_q <= i_wdata;
            end
            if (sel_hit) begin
                func_sel_q[sel_pin] <= i_wdata[4:0];
            end
        end
    end

    assign o_gpio_out = gpio_out_q;
    assign o_func_sel = func_sel_q;

    always_comb begin
        if (i_ofs == GPIO_OUT_OFS) begin
            o_rdata = {24'h0, gpio_out_q};
        end else if (i_ofs == GPIO_IN_OFS) begin
            o_rdata = {24'h0, i_ui_in};
        end else if (sel_hit) begin
            o_rdata = {27'h0, func_sel_q[sel_pin]};
        end else begin
            o_rdata = '0;
        end
    end

endmodule

/* hw/peri_pin_mux.sv */
/*
 * Output pin routing. Each pin follows the GPIO byte or one slot's byte,
 * chosen by its function select; unknown codes drive the pin low.
 */
`timescale 1ns/1ps

module peri_pin_mux import peri_pkg::*; #(
    parameter int NUM_SLOTS = 4
) (
    input  func_sel_t i_func_sel [NUM_PINS],
    input  byte_t     i_gpio_out,
    input  byte_t     i_slot_out [NUM_SLOTS],
    output byte_t     o_uo_out
);

    always_comb begin
        for (int k = 0; k < NUM_PINS; k++) begin
            o_uo_out[k] = 1'b0;
            if (i_func_sel[k] == FUNC_GPIO) begin
                o_uo_out[k] = i_gpio_out[k];
            end
            // Slot codes at or above NUM_SLOTS match nothing and leave 0
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (int'(i_func_sel[k]) == int'(FUNC_SLOT_BASE) + s) begin
                    o_uo_out[k] = i_slot_out[s][k];
                end
            end
        end
    end

endmodule

/* hw/peri_pkg.sv */
/*
 * Shared types and address map for the peripheral bus subsystem.
 * Imported by every RTL module that needs a bus type or a map constant.
 */
package peri_pkg;

    // Request size code from the core, all ones means idle
    typedef enum logic [1:0] {
        BUS_BYTE = 2'b00,
        BUS_HALF = 2'b01,
        BUS_WORD = 2'b10,
        BUS_NONE = 2'b11
    } bus_size_e;

    // Which block answers the current address
    typedef enum logic [1:0] {
        TGT_NONE = 2'd0,
        TGT_GPIO = 2'd1,
        TGT_SLOT = 2'd2
    } peri_target_e;

    typedef logic [31:0] data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [10:0] addr_t;
    typedef logic [4:0]  func_sel_t;

    // Pin function codes, slot n is FUNC_SLOT_BASE + n
    localparam func_sel_t FUNC_GPIO      = 5'd1;
    localparam func_sel_t FUNC_SLOT_BASE = 5'd16;

    localparam int NUM_PINS = 8;

    // Full peripheral region
    localparam addr_t      GPIO_BASE       = 11'h040;
    localparam int         GPIO_WINDOW     = 64;
    localparam logic [5:0] GPIO_OUT_OFS    = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS     = 6'h04;
    localparam logic [5:0] GPIO_SEL_OFS    = 6'h20;
    localparam int         GPIO_SEL_STRIDE = 4;

    // Byte peripheral region
    localparam addr_t      SLOT_BASE      = 11'h400;
    localparam int         SLOT_WINDOW    = 16;
    localparam logic [3:0] SLOT_OUT_OFS   = 4'd0;
    localparam logic [3:0] SLOT_COUNT_OFS = 4'd1;
    localparam logic [3:0] SLOT_PIN_OFS   = 4'd2;

endpackage

/* hw/peri_read_return.sv */
/*
 * Read return path: muxes the selected read word, captures it once per read
 * and holds it until the core signals read complete.
 */
`timescale 1ns/1ps

module peri_read_return import peri_pkg::*; #(
    parameter int NUM_SLOTS = 4
) (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  peri_target_e i_target,
    input  logic [3:0]   i_slot_idx,
    input  data_t        i_gpio_rdata,
    input  byte_t        i_slot_rdata [NUM_SLOTS],
    input  bus_size_e    i_data_read_n,
    input  bus_size_e    i_data_write_n,
    input  logic         i_data_read_complete,
    output data_t        o_data_out,
    output logic         o_data_ready
);

    data_t rdata_mux;
    data_t data_q;
    logic  hold_q;
    logic  ready_q;
    logic  read_req;
    logic  write_req;

    assign read_req  = (i_data_read_n != BUS_NONE);
    assign write_req = (i_data_write_n != BUS_NONE);

    always_comb begin
        rdata_mux = '0;
        case (i_target)
            TGT_GPIO: rdata_mux = i_gpio_rdata;
            TGT_SLOT: begin
                for (int s = 0; s < NUM_SLOTS; s++) begin
                    if (int'(i_slot_idx) == s) begin
                        rdata_mux = {24'h0, i_slot_rdata[s]};
                    end
                end
            end
            default: rdata_mux = '0;
        endcase
    end

    // Capture at the first edge of a read, ready one edge later
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end else if (!hold_q && read_req) begin
                hold_q <= 1'b1;
            end
            ready_q <= read_req && hold_q && !i_data_read_complete;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!hold_q && read_req) begin
            data_q <= rdata_mux;
        end
    end

    assign o_data_out   = data_q;
    // Writes are acknowledged in the cycle they are requested
    assign o_data_ready = ready_q || write_req;

endmodule

/* hw/peri_subsystem.sv */
/*
 * Peripheral bus subsystem top level: decoder, GPIO, byte slots, pin mux
 * and read return. Connects to the core's native request interface.
 */
`timescale 1ns/1ps

module peri_subsystem import peri_pkg::*; #(
    parameter int NUM_SLOTS = 4
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  byte_t     i_ui_in,
    input  addr_t     i_addr,
    input  data_t     i_data_in,
    input  bus_size_e i_data_write_n,
    input  bus_size_e i_data_read_n,
    input  logic      i_data_read_complete,
    output data_t     o_data_out,
    output logic      o_data_ready,
    output byte_t     o_uo_out
);

    peri_target_e         target;
    logic [3:0]           slot_idx;
    logic                 gpio_wr;
    logic [NUM_SLOTS-1:0] slot_wr;

    byte_t                gpio_out;
    func_sel_t            func_sel [NUM_PINS];
    data_t                gpio_rdata;

    byte_t                slot_out   [NUM_SLOTS];
    byte_t                slot_rdata [NUM_SLOTS];

    peri_addr_decode #(
        .NUM_SLOTS      (NUM_SLOTS)
    ) u_decode (
        .i_addr         (i_addr),
        .i_data_write_n (i_data_write_n),
        .o_target       (target),
        .o_slot_idx     (slot_idx),
        .o_gpio_wr      (gpio_wr),
        .o_slot_wr      (slot_wr)
    );

    peri_gpio u_gpio (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_ui_in        (i_ui_in),
        .i_wr           (gpio_wr),
        .i_ofs          (i_addr[5:0]),
        .i_wdata        (i_data_in[7:0]),
        .o_gpio_out     (gpio_out),
        .o_func_sel     (func_sel),
        .o_rdata        (gpio_rdata)
    );

    // One identical byte peripheral per slot
    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
        peri_byte_slot u_slot (
            .i_clk      (i_clk),
            .i_rst_n    (i_rst_n),
            .i_ui_in    (i_ui_in),
            .i_wr       (slot_wr[s]),
            .i_ofs      (i_addr[3:0]),
            .i_wdata    (i_data_in[7:0]),
            .o_out      (slot_out[s]),
            .o_rdata    (slot_rdata[s])
        );
    end

    peri_pin_mux #(
        .NUM_SLOTS      (NUM_SLOTS)
    ) u_pin_mux (
        .i_func_sel     (func_sel),
        .i_gpio_out     (gpio_out),
        .i_slot_out     (slot_out),
        .o_uo_out       (o_uo_out)
    );

    peri_read_return #(
        .NUM_SLOTS            (NUM_SLOTS)
    ) u_read_return (
        .i_clk                (i_clk),
        .i_rst_n              (i_rst_n),
        .i_target             (target),
        .i_slot_idx           (slot_idx),
        .i_gpio_rdata         (gpio_rdata),
        .i_slot_rdata         (slot_rdata),
        .i_data_read_n        (i_data_read_n),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

endmodule

/* peri_bus.f */
hw/peri_pkg.sv
hw/peri_addr_decode.sv
hw/peri_gpio.sv
hw/peri_byte_slot.sv
hw/peri_pin_mux.sv
hw/peri_read_return.sv
hw/peri_subsystem.sv
dv/tb_peri_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f peri_bus.f \
    --top-module tb_peri_subsystem -Mdir obj_dir
out=$(./obj_dir/Vtb_peri_subsystem)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
